//--- msx_glue.f
+incdir+testbench
source/msx_glue_pkg.sv
source/host_ctrl_if.sv
source/host_status_decode.sv
source/sd_card_select.sv
source/cassette_control.sv
source/video_options.sv
source/msx_glue_top.sv
testbench/msx_glue_tb.sv

//--- Bender.yml
package:
  name: msx_glue

sources:
  - files:
      - source/msx_glue_pkg.sv
      - source/host_ctrl_if.sv
      - source/host_status_decode.sv
      - source/sd_card_select.sv
      - source/cassette_control.sv
      - source/video_options.sv
      - source/msx_glue_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/msx_glue_tb.sv

//--- testbench/msx_glue_tests.svh
// Directed tests for resets, video decode, crop, SD select, activity LEDs and cassette control

// Pulse the SD mount strobe for one clock and wait until the card choice is taken
task automatic mount_image(input logic size_nonzero);
   img_size_nonzero     = size_nonzero;
   img_mounted[SD_SLOT] = 1'b1;
   step(1);
   img_mounted[SD_SLOT] = 1'b0;
   step(1);
endtask

// Timer runs out act_hold clocks after the last line change
task automatic wait_led_off(input int elapsed);
   int n;
   n = elapsed;
   while ((led_user || led_disk_act) && n < ACT_HOLD + 4) begin
      step(1);
      n++;
   end
   if (led_user || led_disk_act) begin
      $display("%s: activity LED still lit %0d cycles after the last SPI change",
               test_name, n);
      errors++;
   end else if (n <= ACT_HOLD) begin
      $display("%s: activity LED went dark only %0d cycles after the last SPI change",
               test_name, n);
      errors++;
   end
endtask

task automatic crop_case(input int w, input int h, input logic forced, input ratio_t expected);
   hdmi_width         = 12'(w);
   hdmi_height        = 12'(h);
   forced_scandoubler = forced;
   step(2);
   ratio_equal($sformatf("crop_size %0dx%0d forced %0d", w, h, forced), expected, crop_size);
endtask

task automatic reset_values_test();
   int bits[3] = '{STAT_RESET, STAT_DETACH, STAT_RESET_CLOSE};
   begin_test("reset values");
   bit_equal("hard_reset before first clock", 1'b1, hard_reset);
   bit_equal("core_reset before first clock", 1'b1, core_reset);
   step(1);
   bit_equal("hard_reset", 1'b0, hard_reset);
   bit_equal("core_reset", 1'b0, core_reset);
   bit_equal("sd_cs", 1'b0, sd_cs);
   bit_equal("led_user", 1'b0, led_user);
   bit_equal("led_disk_act", 1'b0, led_disk_act);
   bit_equal("play", 1'b0, play);
   bit_equal("scandoubler", 1'b0, scandoubler);
   bit_equal("hq2x", 1'b0, hq2x);
   foreach (bits[i]) begin
      status[bits[i]] = 1'b1;
      step(1);
      bit_equal($sformatf("core_reset for bit %0d", bits[i]), 1'b1, core_reset);
      bit_equal($sformatf("hard_reset for bit %0d", bits[i]), bits[i] == 0, hard_reset);
      status[bits[i]] = 1'b0;
      step(1);
      bit_equal($sformatf("core_reset after bit %0d", bits[i]), 1'b0, core_reset);
   end
   upload_reset = 1'b1;
   step(1);
   bit_equal("core_reset for upload_reset", 1'b1, core_reset);
   bit_equal("hard_reset for upload_reset", 1'b1, hard_reset);
   upload_reset = 1'b0;
   step(1);
   bit_equal("hard_reset after upload_reset", 1'b0, hard_reset);
   end_test();
endtask

task automatic video_decode_test();
   logic [1:0] exp_sl;
   ratio_t     exp_arx;
   ratio_t     exp_ary;
   begin_test("video decode");
   for (int s = 0; s < 5; s++) begin
      for (int a = 0; a < 4; a++) begin
         status[STAT_SCALE_LO +: 3]  = 3'(s);
         status[STAT_ASPECT_LO +: 2] = 2'(a);
         // Decoder register, then video register
         step(2);
         exp_sl  = (s == 0) ? 2'd0 : 2'(s - 1);
         exp_arx = (a == 0) ? ratio_t'(4) : ratio_t'(a - 1);
         exp_ary = (a == 0) ? ratio_t'(3) : ratio_t'(0);
         sl_equal($sformatf("vga_sl scale %0d", s), exp_sl, vga_sl);
         bit_equal($sformatf("scandoubler scale %0d", s), s != 0, scandoubler);
         bit_equal($sformatf("hq2x scale %0d", s), s == 1, hq2x);
         ratio_equal($sformatf("arx aspect %0d", a), exp_arx, arx);
         ratio_equal($sformatf("ary aspect %0d", a), exp_ary, ary);
      end
   end
   status = '0;
   step(2);
   end_test();
endtask

task automatic crop_test();
   begin_test("crop");
   crop_case(1920, 1080, 1'b0, ratio_t'(216));
   crop_case(1920, 1080, 1'b1, ratio_t'(0));
   crop_case(1280, 720, 1'b0, ratio_t'(0));
   crop_case(1920, 1200, 1'b0, ratio_t'(0));
   // Scandoubler on through the scale option
   status[STAT_SCALE_LO +: 3] = 3'd1;
   crop_case(1920, 1080, 1'b0, ratio_t'(0));
   status = '0;
   crop_case(1280, 720, 1'b0, ratio_t'(0));
   end_test();
endtask

task automatic sd_select_test();
   begin_test("sd select");
   spi_sck  = 1'b1;
   spi_mosi = 1'b1;
   mount_image(1'b1);
   bit_equal("sd_cs virtual", 1'b1, sd_cs);
   bit_equal("sd_sck virtual", 1'b0, sd_sck);
   bit_equal("sd_mosi virtual", 1'b0, sd_mosi);
   vsd_miso = 1'b1;
   sd_miso  = 1'b0;
   step(1);
   bit_equal("core_miso from vsd_miso high", 1'b1, core_miso);
   vsd_miso = 1'b0;
   sd_miso  = 1'b1;
   step(1);
   bit_equal("core_miso from vsd_miso low", 1'b0, core_miso);
   mount_image(1'b0);
   bit_equal("sd_cs physical", 1'b0, sd_cs);
   bit_equal("sd_sck physical", 1'b1, sd_sck);
   bit_equal("sd_mosi physical", 1'b1, sd_mosi);
   bit_equal("core_miso from sd_miso high", 1'b1, core_miso);
   sd_miso  = 1'b0;
   vsd_miso = 1'b1;
   step(1);
   bit_equal("core_miso from sd_miso low", 1'b0, core_miso);
   spi_sck  = 1'b0;
   spi_mosi = 1'b0;
   vsd_miso = 1'b0;
   status[STAT_RESET_AFTER_MOUNT] = 1'b1;
   step(1);
   bit_equal("core_reset without mount", 1'b0, core_reset);
   img_mounted[SD_SLOT] = 1'b1;
   step(1);
   bit_equal("core_reset on mount", 1'b1, core_reset);
   img_mounted[SD_SLOT] = 1'b0;
   step(1);
   bit_equal("core_reset after mount", 1'b0, core_reset);
   status = '0;
   end_test();
endtask

task automatic activity_led_test();
   begin_test("activity leds");
   step(ACT_HOLD + 4);
   bit_equal("led_disk_act quiet", 1'b0, led_disk_act);
   bit_equal("led_user quiet", 1'b0, led_user);
   // Physical card in use
   for (int i = 0; i < 10; i++) begin
      spi_mosi = ~spi_mosi;
      step(1);
      bit_equal("led_disk_act with traffic", 1'b1, led_disk_act);
      bit_equal("led_user with traffic", 1'b0, led_user);
      step(7);
      bit_equal("led_disk_act between toggles", 1'b1, led_disk_act);
   end
   wait_led_off(8);
   mount_image(1'b1);
   for (int i = 0; i < 3; i++) begin
      spi_mosi = ~spi_mosi;
      step(1);
      bit_equal("led_user with traffic", 1'b1, led_user);
      bit_equal("led_disk_act with traffic", 1'b0, led_disk_act);
      step(7);
      bit_equal("led_user between toggles", 1'b1, led_user);
   end
   wait_led_off(8);
   end_test();
endtask

task automatic cassette_test();
   begin_test("cassette control");
   ioctl_index    = 16'd5;
   ioctl_download = 1'b1;
   step(1);
   bit_equal("rewind during download", 1'b1, rewind);
   bit_equal("play during download", 1'b0, play);
   step(4);
   ioctl_download = 1'b0;
   step(2);
   bit_equal("rewind after download", 1'b0, rewind);
   bit_equal("play after download", 1'b1, play);
   motor = 1'b1;
   step(1);
   bit_equal("play with motor on", 1'b0, play);
   motor    = 1'b0;
   cas_dout = 1'b1;
   step(1);
   bit_equal("tape_in file high", 1'b1, tape_in);
   cas_dout = 1'b0;
   step(1);
   bit_equal("tape_in file low", 1'b0, tape_in);
   status[STAT_TAPE_SRC] = 1'b1;
   cas_dout              = 1'b1;
   step(1);
   bit_equal("tape_in adc ignores file", 1'b0, tape_in);
   adc_dout   = 1'b1;
   adc_active = 1'b1;
   step(1);
   bit_equal("tape_in adc active", 1'b1, tape_in);
   adc_active = 1'b0;
   step(1);
   bit_equal("tape_in adc idle", 1'b0, tape_in);
   status   = '0;
   adc_dout = 1'b0;
   cas_dout = 1'b0;
   // Opposite read strobes so the grant shows on ddr3_rd as well
   for (int i = 0; i < 16; i++) begin
      dl_request = i[0];
      dl_addr    = ddr3_addr_t'($urandom);
      dl_rd      = 1'($urandom_range(1, 0));
      cas_addr   = ddr3_addr_t'($urandom);
      cas_rd     = ~dl_rd;
      #1;
      if (dl_request) begin
         addr_equal("ddr3_addr download side", dl_addr, ddr3_addr);
         bit_equal("ddr3_rd download side", dl_rd, ddr3_rd);
      end else begin
         addr_equal("ddr3_addr cassette side", cas_addr, ddr3_addr);
         bit_equal("ddr3_rd cassette side", cas_rd, ddr3_rd);
      end
      step(1);
   end
   end_test();
endtask

//--- testbench/msx_glue_tb.sv
// Testbench for the glue top level with clock, reset, watchdog, compare tasks and test sequence
`timescale 1ns/1ps

module msx_glue_tb;
   import msx_glue_pkg::*;

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 16;
   localparam int ACT_HOLD     = 64;
   // Approximate clocks per test, in run order
   localparam int TEST_CYCLES  = 12 + 40 + 12 + 16 + (4 * ACT_HOLD + 120) + 32;

   logic                     clock_bus;
   logic                     arst_n;
   status_t                  status;
   logic                     upload_reset;
   img_vec_t                 img_mounted;
   logic                     ioctl_download;
   logic [IOCTL_INDEX_W-1:0] ioctl_index;
   logic                     hard_reset;
   logic                     core_reset;
   logic                     img_size_nonzero;
   logic                     spi_sck;
   logic                     spi_mosi;
   logic                     sd_miso;
   logic                     vsd_miso;
   logic                     core_miso;
   logic                     sd_cs;
   logic                     sd_sck;
   logic                     sd_mosi;
   logic                     led_user;
   logic                     led_disk_act;
   logic                     motor;
   logic                     cas_dout;
   logic                     adc_dout;
   logic                     adc_active;
   logic                     dl_request;
   ddr3_addr_t               dl_addr;
   logic                     dl_rd;
   ddr3_addr_t               cas_addr;
   logic                     cas_rd;
   logic                     play;
   logic                     rewind;
   logic                     tape_in;
   ddr3_addr_t               ddr3_addr;
   logic                     ddr3_rd;
   logic                     forced_scandoubler;
   logic [HDMI_DIM_W-1:0]    hdmi_width;
   logic [HDMI_DIM_W-1:0]    hdmi_height;
   logic [1:0]               vga_sl;
   logic                     scandoubler;
   logic                     hq2x;
   ratio_t                   arx;
   ratio_t                   ary;
   ratio_t                   crop_size;

   string test_name;
   int    errors;
   int    errors_at_start;
   int    tests_run;
   int    tests_failed;

   msx_glue_top #(.act_hold(ACT_HOLD)) msx_glue_top_i (.*);

   always #(CLK_PERIOD / 2) clock_bus = ~clock_bus;

   // ======================================================================
   // Helpers and compare tasks
   // ======================================================================
   // Wait for n rising edges, then move 1 ns past the last one
   task automatic step(input int n);
      repeat (n) @(posedge clock_bus);
      #1;
   endtask

   task automatic begin_test(input string name);
      test_name       = name;
      errors_at_start = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors == errors_at_start) begin
         $display("%s: passed", test_name);
      end else begin
         tests_failed++;
         $display("%s: %0d checks failed", test_name, errors - errors_at_start);
      end
   endtask

   task automatic bit_equal(input string what, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("FAILED %s: %s expected %b, actual %b", test_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic ratio_equal(input string what, input ratio_t expected, input ratio_t actual);
      if (actual !== expected) begin
         $display("FAILED %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic addr_equal(input string what, input ddr3_addr_t expected,
                             input ddr3_addr_t actual);
      if (actual !== expected) begin
         $display("FAILED %s: %s expected %h, actual %h", test_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic sl_equal(input string what, input logic [1:0] expected,
                           input logic [1:0] actual);
      if (actual !== expected) begin
         $display("FAILED %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
         errors++;
      end
   endtask

   `include "msx_glue_tests.svh"

   // ======================================================================
   // Watchdog and test sequence
   // ======================================================================
   initial begin : watchdog
      #((RESET_CYCLES + 4 * TEST_CYCLES) * CLK_PERIOD);
      $display("Watchdog expired, the test sequence did not finish in time");
      $display("TESTS FAILED");
      $finish;
   end

   initial begin : main_sequence
      int seed_value;
      seed_value         = $urandom(32'h9dee);
      clock_bus          = 1'b0;
      arst_n             = 1'b0;
      status             = '0;
      upload_reset       = 1'b0;
      img_mounted        = '0;
      ioctl_download     = 1'b0;
      ioctl_index        = '0;
      img_size_nonzero   = 1'b0;
      spi_sck            = 1'b0;
      spi_mosi           = 1'b0;
      sd_miso            = 1'b0;
      vsd_miso           = 1'b0;
      motor              = 1'b0;
      cas_dout           = 1'b0;
      adc_dout           = 1'b0;
      adc_active         = 1'b0;
      dl_request         = 1'b0;
      dl_addr            = '0;
      dl_rd              = 1'b0;
      cas_addr           = '0;
      cas_rd             = 1'b0;
      forced_scandoubler = 1'b0;
      hdmi_width         = 12'd1280;
      hdmi_height        = 12'd720;
      errors             = 0;
      tests_run          = 0;
      tests_failed       = 0;

      repeat (RESET_CYCLES) @(posedge clock_bus);
      #1;
      arst_n = 1'b1;

      reset_values_test();
      video_decode_test();
      crop_test();
      sd_select_test();
      activity_led_test();
      cassette_test();

      $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- source/msx_glue_top.sv
// Top level of the MSX glue logic joining decoder, SD select, cassette and video blocks
`timescale 1ns/1ps

module msx_glue_top #(
   parameter int act_hold = msx_glue_pkg::ACT_HOLD_DEFAULT
) (
   input  logic                                   clock_bus,
   input  logic                                   arst_n,
   // Host side
   input  msx_glue_pkg::status_t                  status,
   input  logic                                   upload_reset,
   input  msx_glue_pkg::img_vec_t                 img_mounted,
   input  logic                                   ioctl_download,
   input  logic [msx_glue_pkg::IOCTL_INDEX_W-1:0] ioctl_index,
   output logic                                   hard_reset,
   output logic                                   core_reset,
   // SD card
   input  logic                                   img_size_nonzero,
   input  logic                                   spi_sck,
   input  logic                                   spi_mosi,
   input  logic                                   sd_miso,
   input  logic                                   vsd_miso,
   output logic                                   core_miso,
   output logic                                   sd_cs,
   output logic                                   sd_sck,
   output logic                                   sd_mosi,
   output logic                                   led_user,
   output logic                                   led_disk_act,
   // Cassette and DDR3 read port
   input  logic                                   motor,
   input  logic                                   cas_dout,
   input  logic                                   adc_dout,
   input  logic                                   adc_active,
   input  logic                                   dl_request,
   input  msx_glue_pkg::ddr3_addr_t               dl_addr,
   input  logic                                   dl_rd,
   input  msx_glue_pkg::ddr3_addr_t               cas_addr,
   input  logic                                   cas_rd,
   output logic                                   play,
   output logic                                   rewind,
   output logic                                   tape_in,
   output msx_glue_pkg::ddr3_addr_t               ddr3_addr,
   output logic                                   ddr3_rd,
   // Video
   input  logic                                   forced_scandoubler,
   input  logic [msx_glue_pkg::HDMI_DIM_W-1:0]    hdmi_width,
   input  logic [msx_glue_pkg::HDMI_DIM_W-1:0]    hdmi_height,
   output logic [1:0]                             vga_sl,
   output logic                                   scandoubler,
   output logic                                   hq2x,
   output msx_glue_pkg::ratio_t                   arx,
   output msx_glue_pkg::ratio_t                   ary,
   output msx_glue_pkg::ratio_t                   crop_size
);

   host_ctrl_if host_ctrl ();

   assign core_reset = host_ctrl.core_reset;

   host_status_decode host_status_decode_i (
      .clock_bus      (clock_bus),
      .arst_n         (arst_n),
      .status         (status),
      .upload_reset   (upload_reset),
      .img_mounted    (img_mounted),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .hard_reset     (hard_reset),
      .host           (host_ctrl.decode)
   );

   sd_card_select #(.act_hold(act_hold)) sd_card_select_i (
      .clock_bus        (clock_bus),
      .arst_n           (arst_n),
      .host             (host_ctrl.sd),
      .img_size_nonzero (img_size_nonzero),
      .spi_sck          (spi_sck),
      .spi_mosi         (spi_mosi),
      .sd_miso          (sd_miso),
      .vsd_miso         (vsd_miso),
      .core_miso        (core_miso),
      .sd_cs            (sd_cs),
      .sd_sck           (sd_sck),
      .sd_mosi          (sd_mosi),
      .led_user         (led_user),
      .led_disk_act     (led_disk_act)
   );

   cassette_control cassette_control_i (
      .clock_bus  (clock_bus),
      .arst_n     (arst_n),
      .host       (host_ctrl.cassette),
      .motor      (motor),
      .cas_dout   (cas_dout),
      .adc_dout   (adc_dout),
      .adc_active (adc_active),
      .dl_request (dl_request),
      .dl_addr    (dl_addr),
      .dl_rd      (dl_rd),
      .cas_addr   (cas_addr),
      .cas_rd     (cas_rd),
      .play       (play),
      .rewind     (rewind),
      .tape_in    (tape_in),
      .ddr3_addr  (ddr3_addr),
      .ddr3_rd    (ddr3_rd)
   );

   video_options video_options_i (
      .clock_bus          (clock_bus),
      .arst_n             (arst_n),
      .host               (host_ctrl.video),
      .forced_scandoubler (forced_scandoubler),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .vga_sl             (vga_sl),
      .scandoubler        (scandoubler),
      .hq2x               (hq2x),
      .arx                (arx),
      .ary                (ary),
      .crop_size          (crop_size)
   );

endmodule

//--- source/video_options.sv
// Scaler settings, aspect ratio and 1080p crop derived from the video options
`timescale 1ns/1ps

module video_options (
   input  logic                                clock_bus,
   input  logic                                arst_n,
   host_ctrl_if.video                          host,
   input  logic                                forced_scandoubler,
   input  logic [msx_glue_pkg::HDMI_DIM_W-1:0] hdmi_width,
   input  logic [msx_glue_pkg::HDMI_DIM_W-1:0] hdmi_height,
   output logic [1:0]                          vga_sl,
   output logic                                scandoubler,
   output logic                                hq2x,
   output msx_glue_pkg::ratio_t                arx,
   output msx_glue_pkg::ratio_t                ary,
   output msx_glue_pkg::ratio_t                crop_size
);
   import msx_glue_pkg::*;

   logic [SCALE_W-1:0] sl_full;
   logic               sd_next;
   logic               crop_next;

   // CRT levels map to scanline codes 1..3
   assign sl_full = (host.scale == SCALE_NONE) ? '0 : SCALE_W'(host.scale) - SCALE_W'(1);
   assign sd_next = forced_scandoubler | (host.scale != SCALE_NONE);

   // Crop only for a native 1080p output without scandoubler
   assign crop_next = (hdmi_width == HDMI_DIM_W'(HDMI_1080_W)) &&
                      (hdmi_height == HDMI_DIM_W'(HDMI_1080_H)) && !sd_next;

   always_ff @(posedge clock_bus or negedge arst_n) begin
      if (!arst_n) begin
         vga_sl      <= '0;
         scandoubler <= 1'b0;
         hq2x        <= 1'b0;
         arx         <= '0;
         ary         <= '0;
         crop_size   <= '0;
      end else begin
         vga_sl      <= sl_full[1:0];
         scandoubler <= sd_next;
         hq2x        <= host.scale == SCALE_HQ2X;
         if (host.aspect == ASPECT_ORIGINAL) begin
            arx <= ratio_t'(ARX_ORIGINAL);
            ary <= ratio_t'(ARY_ORIGINAL);
         end else begin
            // Scaler reads ARY zero as a preset index in ARX
            arx <= ratio_t'(host.aspect) - ratio_t'(1);
            ary <= '0;
         end
         crop_size   <= crop_next ? ratio_t'(CROP_1080) : '0;
      end
   end

endmodule

//--- source/cassette_control.sv
// Cassette load latch, player controls, tape input choice and DDR3 read port grant
`timescale 1ns/1ps

module cassette_control (
   input  logic                     clock_bus,
   input  logic                     arst_n,
   host_ctrl_if.cassette            host,
   input  logic                     motor,
   input  logic                     cas_dout,
   input  logic                     adc_dout,
   input  logic                     adc_active,
   input  logic                     dl_request,
   input  msx_glue_pkg::ddr3_addr_t dl_addr,
   input  logic                     dl_rd,
   input  msx_glue_pkg::ddr3_addr_t cas_addr,
   input  logic                     cas_rd,
   output logic                     play,
   output logic                     rewind,
   output logic                     tape_in,
   output msx_glue_pkg::ddr3_addr_t ddr3_addr,
   output logic                     ddr3_rd
);
   import msx_glue_pkg::*;

   logic cas_download_last;
   logic cas_load;

   // ======================================================================
   // Load latch
   // ======================================================================
   // Set at the end of a cassette file download, kept until board reset
   always_ff @(posedge clock_bus or negedge arst_n) begin
      if (!arst_n) begin
         cas_download_last <= 1'b0;
         cas_load          <= 1'b0;
      end else begin
         cas_download_last <= host.cas_download;
         if (cas_download_last & ~host.cas_download) begin
            cas_load <= 1'b1;
         end
      end
   end

   // Player runs while the machine has the motor relay off
   assign play   = cas_load & ~motor;
   assign rewind = host.rewind_req | host.cas_download | host.core_reset;

   // ADC sample only counts while the converter sees a signal
   assign tape_in = (host.tape_src == TAPE_FILE) ? cas_dout : (adc_dout & adc_active);

   // ======================================================================
   // DDR3 read port
   // ======================================================================
   // ROM download has priority over the tape player
   assign ddr3_addr = dl_request ? dl_addr : cas_addr;
   assign ddr3_rd   = dl_request ? dl_rd : cas_rd;

endmodule

//--- source/sd_card_select.sv
// Virtual or physical SD card select, SPI routing and disk activity LEDs
`timescale 1ns/1ps

module sd_card_select #(
   parameter int act_hold = msx_glue_pkg::ACT_HOLD_DEFAULT
) (
   input  logic    clock_bus,
   input  logic    arst_n,
   host_ctrl_if.sd host,
   input  logic    img_size_nonzero,
   input  logic    spi_sck,
   input  logic    spi_mosi,
   input  logic    sd_miso,
   input  logic    vsd_miso,
   output logic    core_miso,
   output logic    sd_cs,
   output logic    sd_sck,
   output logic    sd_mosi,
   output logic    led_user,
   output logic    led_disk_act
);
   localparam int TIMER_W = $clog2(act_hold + 1);

   logic               vsd_sel;
   logic               primed;
   logic               mosi_last;
   logic               miso_last;
   logic               spi_change;
   logic [TIMER_W-1:0] act_timer;
   logic               sd_act;

   // Card choice follows the size of the last mounted image
   always_ff @(posedge clock_bus or negedge arst_n) begin
      if (!arst_n) begin
         vsd_sel <= 1'b0;
      end else if (host.sd_mount) begin
         vsd_sel <= img_size_nonzero;
      end
   end

   // ======================================================================
   // SPI routing
   // ======================================================================
   assign sd_cs     = vsd_sel;
   assign sd_sck    = spi_sck & ~vsd_sel;
   assign sd_mosi   = spi_mosi & ~vsd_sel;
   assign core_miso = vsd_sel ? vsd_miso : sd_miso;

   // ======================================================================
   // Activity timer
   // ======================================================================
   // First clock after reset only loads the line history
   assign spi_change = primed & ((mosi_last ^ spi_mosi) | (miso_last ^ core_miso));

   always_ff @(posedge clock_bus or negedge arst_n) begin
      if (!arst_n) begin
         primed    <= 1'b0;
         mosi_last <= 1'b0;
         miso_last <= 1'b0;
         act_timer <= TIMER_W'(act_hold);
      end else begin
         primed    <= 1'b1;
         mosi_last <= spi_mosi;
         miso_last <= core_miso;
         if (spi_change) begin
            act_timer <= '0;
         end else if (act_timer < TIMER_W'(act_hold)) begin
            act_timer <= act_timer + 1'b1;
         end
      end
   end

   assign sd_act       = act_timer < TIMER_W'(act_hold);
   assign led_user     = vsd_sel & sd_act;
   assign led_disk_act = ~vsd_sel & sd_act;

endmodule

//--- source/host_status_decode.sv
// Host status decoder with registered option fields, mount pulse and reset composition
`timescale 1ns/1ps

module host_status_decode (
   input  logic                                   clock_bus,
   input  logic                                   arst_n,
   input  msx_glue_pkg::status_t                  status,
   input  logic                                   upload_reset,
   input  msx_glue_pkg::img_vec_t                 img_mounted,
   input  logic                                   ioctl_download,
   input  logic [msx_glue_pkg::IOCTL_INDEX_W-1:0] ioctl_index,
   output logic                                   hard_reset,
   host_ctrl_if.decode                            host
);
   import msx_glue_pkg::*;

   logic mount_last;
   logic mount_edge;
   logic is_cas;
   logic hard_next;
   logic core_next;

   // Rising edge of the SD image mount strobe
   assign mount_edge = img_mounted[SD_SLOT] & ~mount_last;

   assign is_cas = ioctl_download &
                   (ioctl_index[FILE_SLOT_W-1:0] == FILE_SLOT_W'(CAS_IOCTL_INDEX));

   // ======================================================================
   // Reset composition
   // ======================================================================
   assign hard_next = status[STAT_RESET] | upload_reset;

   assign core_next = hard_next
                    | status[STAT_DETACH]
                    | status[STAT_RESET_CLOSE]
                    | (status[STAT_RESET_AFTER_MOUNT] & mount_edge);

   always_ff @(posedge clock_bus or negedge arst_n) begin
      if (!arst_n) begin
         // Both resets held while the board reset is asserted
         hard_reset        <= 1'b1;
         host.core_reset   <= 1'b1;
         mount_last        <= 1'b0;
         host.sd_mount     <= 1'b0;
         host.cas_download <= 1'b0;
         host.rewind_req   <= 1'b0;
         host.aspect       <= ASPECT_ORIGINAL;
         host.scale        <= SCALE_NONE;
         host.tape_src     <= TAPE_FILE;
      end else begin
         hard_reset        <= hard_next;
         host.core_reset   <= core_next;
         mount_last        <= img_mounted[SD_SLOT];
         host.sd_mount     <= mount_edge;
         host.cas_download <= is_cas;
         host.rewind_req   <= status[STAT_TAPE_REWIND];
         host.aspect       <= aspect_e'(status[STAT_ASPECT_LO +: ASPECT_W]);
         host.scale        <= scale_e'(status[STAT_SCALE_LO +: SCALE_W]);
         host.tape_src     <= tape_src_e'(status[STAT_TAPE_SRC]);
      end
   end

endmodule

//--- source/host_ctrl_if.sv
// Decoded host controls passed from the status decoder to the glue blocks
`timescale 1ns/1ps

interface host_ctrl_if;
   import msx_glue_pkg::*;

   logic      core_reset;
   aspect_e   aspect;
   scale_e    scale;
   tape_src_e tape_src;
   logic      rewind_req;
   // One clock per SD image mount
   logic      sd_mount;
   logic      cas_download;

   modport decode (
      output core_reset, aspect, scale, tape_src, rewind_req, sd_mount, cas_download
   );

   modport sd (input sd_mount);

   modport cassette (input core_reset, tape_src, rewind_req, cas_download);

   modport video (input aspect, scale);

endinterface

//--- source/msx_glue_pkg.sv
// Status bit map, field widths, option enums and shared constants of the glue logic
package msx_glue_pkg;

   // ======================================================================
   // Host status word
   // ======================================================================
   localparam int STATUS_W = 64;
   typedef logic [STATUS_W-1:0] status_t;

   localparam int STAT_RESET             = 0;
   localparam int STAT_ASPECT_LO         = 1;
   localparam int STAT_SCALE_LO          = 3;
   localparam int STAT_TAPE_REWIND       = 9;
   localparam int STAT_DETACH            = 10;
   localparam int STAT_RESET_AFTER_MOUNT = 12;
   localparam int STAT_RESET_CLOSE       = 21;
   localparam int STAT_TAPE_SRC          = 40;

   // ======================================================================
   // Option codes and widths
   // ======================================================================
   localparam int ASPECT_W = 2;
   localparam int SCALE_W  = 3;

   typedef enum logic [ASPECT_W-1:0] {
      ASPECT_ORIGINAL, ASPECT_FULL, ASPECT_ARC1, ASPECT_ARC2
   } aspect_e;

   // Codes 5..7 are unused by the menu
   typedef enum logic [SCALE_W-1:0] {
      SCALE_NONE, SCALE_HQ2X, SCALE_CRT25, SCALE_CRT50, SCALE_CRT75
   } scale_e;

   typedef enum logic {TAPE_FILE, TAPE_ADC} tape_src_e;

   localparam int RATIO_W       = 12;
   localparam int HDMI_DIM_W    = 12;
   localparam int DDR3_ADDR_W   = 28;
   localparam int VDNUM         = 7;
   localparam int IOCTL_INDEX_W = 16;
   // Menu file slot sits in the low bits of the download index
   localparam int FILE_SLOT_W   = 6;

   typedef logic [RATIO_W-1:0]     ratio_t;
   typedef logic [DDR3_ADDR_W-1:0] ddr3_addr_t;
   typedef logic [VDNUM-1:0]       img_vec_t;

   // ======================================================================
   // Constants
   // ======================================================================
   localparam int SD_SLOT          = 4;
   localparam int CAS_IOCTL_INDEX  = 5;
   localparam int ACT_HOLD_DEFAULT = 1000000;
   localparam int HDMI_1080_W      = 1920;
   localparam int HDMI_1080_H      = 1080;
   localparam int CROP_1080        = 216;
   localparam int ARX_ORIGINAL     = 4;
   localparam int ARY_ORIGINAL     = 3;

endpackage
